/* rtl/llc_mem_pkg.sv */
package llc_mem_pkg;

    localparam int llc_set_bits = 6;
    localparam int llc_sets     = 1 << llc_set_bits;
    localparam int llc_ways     = 4;
    localparam int llc_way_bits = 2;
    localparam int llc_tag_bits = 16;
    localparam int line_bits    = 32;
    localparam int wb_adr_bits  = 10;
    localparam int wb_dat_bits  = 32;

    // word address map: field, then way, then set
    localparam int adr_fld_lsb = 0;
    localparam int adr_way_lsb = 2;
    localparam int adr_set_lsb = 4;

    typedef logic [llc_set_bits-1:0] llc_set_t;
    typedef logic [llc_way_bits-1:0] llc_way_t;

    typedef enum logic [2:0] {
        llc_invalid   = 3'd0,
        llc_valid     = 3'd1,
        llc_shared    = 3'd2,
        llc_exclusive = 3'd3,
        llc_modified  = 3'd4
    } llc_state_e;

    typedef enum logic [1:0] {
        fld_line  = 2'd0,
        fld_meta  = 2'd1,
        fld_evict = 2'd2,
        fld_flush = 2'd3
    } llc_field_e;

    // tag in the low bits so the bus image is the struct itself
    typedef struct packed {
        logic                    dirty;
        llc_state_e              state;
        logic [llc_tag_bits-1:0] tag;
    } llc_meta_t;

    localparam int meta_bits = $bits(llc_meta_t);

    typedef struct packed {
        llc_set_t             set_idx;
        llc_way_t             way_idx;
        logic                 line_we;
        logic                 meta_we;
        logic                 evict_we;
        logic [llc_ways-1:0]  flush_mask;
        logic [line_bits-1:0] line;
        llc_meta_t            meta;
        llc_way_t             evict_way;
    } llc_wr_t;

    typedef struct packed {
        llc_field_e field;
        llc_way_t   way_idx;
    } llc_sel_t;

    typedef struct packed {
        logic [llc_ways-1:0][line_bits-1:0] line;
        llc_meta_t [llc_ways-1:0]           meta;
        llc_way_t                           evict_way;
    } llc_rd_t;

endpackage

/* rtl/llc_req_decoder.sv */
module llc_req_decoder (
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [llc_mem_pkg::wb_adr_bits-1:0]  wb_adr,
    input  logic [llc_mem_pkg::wb_dat_bits-1:0]  wb_wdat,
    input  logic                                 wb_ack,
    output llc_mem_pkg::llc_wr_t                 wr,
    output llc_mem_pkg::llc_set_t                rd_set,
    output llc_mem_pkg::llc_sel_t                sel,
    output logic                                 accept
);

    llc_mem_pkg::llc_field_e field;
    llc_mem_pkg::llc_way_t   way_idx;
    llc_mem_pkg::llc_set_t   set_idx;
    logic                    wr_acc;

    // address split
    assign field   = llc_mem_pkg::llc_field_e'(
                         wb_adr[llc_mem_pkg::adr_fld_lsb +: $bits(llc_mem_pkg::llc_field_e)]);
    assign way_idx = wb_adr[llc_mem_pkg::adr_way_lsb +: llc_mem_pkg::llc_way_bits];
    assign set_idx = wb_adr[llc_mem_pkg::adr_set_lsb +: llc_mem_pkg::llc_set_bits];

    // a request still up while ack is high was already taken
    assign accept = wb_cyc & wb_stb & ~wb_ack;
    assign wr_acc = accept & wb_we;

    always_comb begin
        wr.set_idx  = set_idx;
        wr.way_idx  = way_idx;
        wr.line_we  = wr_acc && (field == llc_mem_pkg::fld_line);
        wr.meta_we  = wr_acc && (field == llc_mem_pkg::fld_meta);
        wr.evict_we = wr_acc && (field == llc_mem_pkg::fld_evict);

        // flush takes its way mask from the data bus
        if (wr_acc && (field == llc_mem_pkg::fld_flush)) begin
            wr.flush_mask = wb_wdat[llc_mem_pkg::llc_ways-1:0];
        end else begin
            wr.flush_mask = '0;
        end

        wr.line      = wb_wdat[llc_mem_pkg::line_bits-1:0];
        wr.meta      = llc_mem_pkg::llc_meta_t'(wb_wdat[llc_mem_pkg::meta_bits-1:0]);
        wr.evict_way = wb_wdat[llc_mem_pkg::llc_way_bits-1:0];
    end

    assign rd_set = set_idx;

    always_comb begin
        sel.field   = field;
        sel.way_idx = way_idx;
    end

endmodule

/* rtl/llc_way_store.sv */
module llc_way_store (
    input  logic                  clk,
    input  llc_mem_pkg::llc_wr_t  wr,
    input  llc_mem_pkg::llc_set_t rd_set,
    input  logic                  rd_en,
    output llc_mem_pkg::llc_rd_t  rd
);

    logic [llc_mem_pkg::line_bits-1:0] rd_line [llc_mem_pkg::llc_ways];
    llc_mem_pkg::llc_meta_t            rd_meta [llc_mem_pkg::llc_ways];

    llc_mem_pkg::llc_way_t evict_mem [llc_mem_pkg::llc_sets];
    llc_mem_pkg::llc_way_t rd_evict;

    for (genvar w = 0; w < llc_mem_pkg::llc_ways; w++) begin : g_way
        logic [llc_mem_pkg::line_bits-1:0] line_mem [llc_mem_pkg::llc_sets];
        llc_mem_pkg::llc_meta_t            meta_mem [llc_mem_pkg::llc_sets];
        logic                              way_hit;

        assign way_hit = (wr.way_idx == llc_mem_pkg::llc_way_bits'(w));

        always_ff @(posedge clk) begin
            if (wr.line_we && way_hit) begin
                line_mem[wr.set_idx] <= wr.line;
            end

            if (wr.meta_we && way_hit) begin
                meta_mem[wr.set_idx] <= wr.meta;
            end else if (wr.flush_mask[w]) begin
                // tag is kept so the line can still be identified
                meta_mem[wr.set_idx].state <= llc_mem_pkg::llc_invalid;
                meta_mem[wr.set_idx].dirty <= 1'b0;
            end

            // old contents come out on a same-set write
            if (rd_en) begin
                rd_line[w] <= line_mem[rd_set];
                rd_meta[w] <= meta_mem[rd_set];
            end
        end
    end

    // one eviction pointer per set, shared by all ways
    always_ff @(posedge clk) begin
        if (wr.evict_we) begin
            evict_mem[wr.set_idx] <= wr.evict_way;
        end
        if (rd_en) begin
            rd_evict <= evict_mem[rd_set];
        end
    end

    always_comb begin
        for (int w = 0; w < llc_mem_pkg::llc_ways; w++) begin
            rd.line[w] = rd_line[w];
            rd.meta[w] = rd_meta[w];
        end
        rd.evict_way = rd_evict;
    end

endmodule

/* rtl/llc_rsp_mux.sv */
module llc_rsp_mux (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                accept,
    input  llc_mem_pkg::llc_sel_t               sel,
    input  llc_mem_pkg::llc_rd_t                rd,
    output logic [llc_mem_pkg::wb_dat_bits-1:0] wb_rdat,
    output logic                                wb_ack
);

    llc_mem_pkg::llc_sel_t sel_q;

    // ack and select line up with the store's registered read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            sel_q  <= '0;
        end else begin
            wb_ack <= accept;
            if (accept) begin
                sel_q <= sel;
            end
        end
    end

    // data bus is quiet outside the ack cycle
    always_comb begin
        wb_rdat = '0;
        if (wb_ack) begin
            case (sel_q.field)
                llc_mem_pkg::fld_line: begin
                    wb_rdat = llc_mem_pkg::wb_dat_bits'(rd.line[sel_q.way_idx]);
                end
                llc_mem_pkg::fld_meta: begin
                    wb_rdat = llc_mem_pkg::wb_dat_bits'(rd.meta[sel_q.way_idx]);
                end
                llc_mem_pkg::fld_evict: begin
                    wb_rdat = llc_mem_pkg::wb_dat_bits'(rd.evict_way);
                end
                default: begin
                    // flush field has nothing to read
                    wb_rdat = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/llc_mem_top.sv */
module llc_mem_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [llc_mem_pkg::wb_adr_bits-1:0] wb_adr,
    input  logic [llc_mem_pkg::wb_dat_bits-1:0] wb_wdat,
    output logic [llc_mem_pkg::wb_dat_bits-1:0] wb_rdat,
    output logic                                wb_ack
);

    llc_mem_pkg::llc_wr_t  wr;
    llc_mem_pkg::llc_set_t rd_set;
    llc_mem_pkg::llc_sel_t sel;
    llc_mem_pkg::llc_rd_t  rd;
    logic                  accept;

    llc_req_decoder u_decoder (
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_wdat (wb_wdat),
        .wb_ack  (wb_ack),
        .wr      (wr),
        .rd_set  (rd_set),
        .sel     (sel),
        .accept  (accept)
    );

    // every accepted access reads the set, writes included
    llc_way_store u_store (
        .clk    (clk),
        .wr     (wr),
        .rd_set (rd_set),
        .rd_en  (accept),
        .rd     (rd)
    );

    llc_rsp_mux u_rsp (
        .clk     (clk),
        .arst_n  (arst_n),
        .accept  (accept),
        .sel     (sel),
        .rd      (rd),
        .wb_rdat (wb_rdat),
        .wb_ack  (wb_ack)
    );

endmodule

/* tests/llc_mem_props.sv */
module llc_mem_props (
    input logic clk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // classic slave acks for one cycle only
    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack
    ) else $error("wb_ack high two cycles running");

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack without a request in the cycle before");

    a_ack_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !wb_ack
    ) else $error("wb_ack high while reset is asserted");

endmodule

bind llc_mem_top llc_mem_props u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

/* tests/llc_mem_tb.sv */
module llc_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ack_timeout = 16;

    typedef struct packed {
        logic                                we;
        llc_mem_pkg::llc_field_e             fld;
        llc_mem_pkg::llc_way_t               way;
        llc_mem_pkg::llc_set_t               set_idx;
        logic [llc_mem_pkg::wb_dat_bits-1:0] wdat;
        logic [llc_mem_pkg::wb_dat_bits-1:0] exp_rdat;
    } step_t;

    logic                                clk = 1'b0;
    logic                                arst_n;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    logic [llc_mem_pkg::wb_adr_bits-1:0] wb_adr;
    logic [llc_mem_pkg::wb_dat_bits-1:0] wb_wdat;
    logic [llc_mem_pkg::wb_dat_bits-1:0] wb_rdat;
    logic                                wb_ack;

    step_t       steps[$];
    logic [31:0] lfsr_state    = 32'h75d4_f592;
    int          reads_checked = 0;
    int          value_errors  = 0;
    int          bus_errors    = 0;

    always #10 clk = ~clk;

    llc_mem_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_wdat (wb_wdat),
        .wb_rdat (wb_rdat),
        .wb_ack  (wb_ack)
    );

    // taps 32 22 2 1, one shift per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // bus image: tag 15..0, state 18..16, dirty 19
    function automatic logic [31:0] meta_word(input logic [15:0] tag,
                                              input llc_mem_pkg::llc_state_e state,
                                              input logic dirty);
        return {12'h000, dirty, state, tag};
    endfunction

    task automatic add_step(input logic we, input llc_mem_pkg::llc_field_e fld,
                            input int way, input int set_idx,
                            input logic [31:0] wdat, input logic [31:0] exp_rdat);
        step_t s;
        s.we       = we;
        s.fld      = fld;
        s.way      = llc_mem_pkg::llc_way_t'(way);
        s.set_idx  = llc_mem_pkg::llc_set_t'(set_idx);
        s.wdat     = wdat;
        s.exp_rdat = exp_rdat;
        steps.push_back(s);
    endtask

    task automatic build_steps();
        logic [31:0]             line [4];
        logic [15:0]             tag [4];
        llc_mem_pkg::llc_state_e state [4];
        logic                    dirty [4];
        logic [31:0]             exp;
        int                      set_a;
        int                      set_b;
        set_a = 13;
        set_b = 40;
        state = '{llc_mem_pkg::llc_modified, llc_mem_pkg::llc_shared,
                  llc_mem_pkg::llc_exclusive, llc_mem_pkg::llc_valid};
        dirty = '{1'b1, 1'b0, 1'b1, 1'b1};
        for (int w = 0; w < 4; w++) begin
            line[w] = random_bits(32);
            add_step(1'b1, llc_mem_pkg::fld_line, w, set_a, line[w], '0);
        end
        for (int w = 0; w < 4; w++) begin
            add_step(1'b0, llc_mem_pkg::fld_line, w, set_a, '0, line[w]);
        end
        // junk above bit 19 must not be stored
        for (int w = 0; w < 4; w++) begin
            tag[w] = random_bits(16);
            exp = meta_word(tag[w], state[w], dirty[w]) | (random_bits(12) << 20);
            add_step(1'b1, llc_mem_pkg::fld_meta, w, set_a, exp, '0);
        end
        for (int w = 0; w < 4; w++) begin
            exp = meta_word(tag[w], state[w], dirty[w]);
            add_step(1'b0, llc_mem_pkg::fld_meta, w, set_a, '0, exp);
        end
        // second set written first, way bits of the address are ignored
        add_step(1'b1, llc_mem_pkg::fld_evict, 3, set_b, 32'hdead_bee1, '0);
        add_step(1'b1, llc_mem_pkg::fld_evict, 0, set_a, 32'hffff_fff7, '0);
        add_step(1'b0, llc_mem_pkg::fld_evict, 2, set_a, '0, 32'd3);
        add_step(1'b0, llc_mem_pkg::fld_evict, 1, set_b, '0, 32'd1);
        // flush ways 0 and 2
        add_step(1'b1, llc_mem_pkg::fld_flush, 1, set_a, 32'h0000_fff5, '0);
        for (int w = 0; w < 4; w++) begin
            if (w % 2 == 0) begin
                exp = meta_word(tag[w], llc_mem_pkg::llc_invalid, 1'b0);
            end else begin
                exp = meta_word(tag[w], state[w], dirty[w]);
            end
            add_step(1'b0, llc_mem_pkg::fld_meta, w, set_a, '0, exp);
        end
        add_step(1'b0, llc_mem_pkg::fld_line, 2, set_a, '0, line[2]);
        add_step(1'b0, llc_mem_pkg::fld_flush, 2, set_a, '0, '0);
    endtask

    task automatic compare_line(input string name,
                                input logic [llc_mem_pkg::line_bits-1:0] got,
                                input logic [llc_mem_pkg::line_bits-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_meta(input string name, input llc_mem_pkg::llc_meta_t got,
                                input llc_mem_pkg::llc_meta_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s got tag %h state %h dirty %h expected tag %h state %h dirty %h",
                     name, got.tag, got.state, got.dirty, exp.tag, exp.state, exp.dirty);
        end
    endtask

    task automatic check_read(input step_t s, input logic [31:0] rdat);
        reads_checked++;
        case (s.fld)
            llc_mem_pkg::fld_meta, llc_mem_pkg::fld_evict: begin
                compare_meta("wb_rdat",
                             llc_mem_pkg::llc_meta_t'(rdat[llc_mem_pkg::meta_bits-1:0]),
                             llc_mem_pkg::llc_meta_t'(s.exp_rdat[llc_mem_pkg::meta_bits-1:0]));
                compare_line("wb_rdat upper bits", rdat >> llc_mem_pkg::meta_bits,
                             s.exp_rdat >> llc_mem_pkg::meta_bits);
            end
            default: begin
                compare_line("wb_rdat", rdat, s.exp_rdat);
            end
        endcase
    endtask

    // one classic cycle, data sampled at the falling edge
    task automatic bus_access(input step_t s, output logic [31:0] rdat, output logic acked);
        int cycles;
        cycles = 0;
        acked  = 1'b0;
        rdat   = '0;
        @(posedge clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= s.we;
        wb_adr  <= {s.set_idx, s.way, s.fld};
        wb_wdat <= s.wdat;
        while (!acked && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_rdat;
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!acked) begin
            bus_errors++;
            $display("no acknowledge within %0d cycles for set %0d way %0d",
                     ack_timeout, s.set_idx, s.way);
        end else begin
            @(negedge clk);
            if (wb_ack) begin
                bus_errors++;
                $display("acknowledge stayed high a second cycle for set %0d way %0d",
                         s.set_idx, s.way);
            end
        end
    endtask

    initial begin : run
        logic [31:0] rdat;
        logic        acked;
        arst_n  = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        build_steps();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        foreach (steps[i]) begin
            bus_access(steps[i], rdat, acked);
            if (acked && !steps[i].we) begin
                check_read(steps[i], rdat);
            end
        end
        $display("accesses %0d, reads checked %0d, value errors %0d, bus errors %0d",
                 steps.size(), reads_checked, value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* llc_mem.f */
rtl/llc_mem_pkg.sv
rtl/llc_req_decoder.sv
rtl/llc_way_store.sv
rtl/llc_rsp_mux.sv
rtl/llc_mem_top.sv
tests/llc_mem_props.sv
tests/llc_mem_tb.sv

/* Bender.yml */
package:
  name: llc_mem

sources:
  - files:
      - rtl/llc_mem_pkg.sv
      - rtl/llc_req_decoder.sv
      - rtl/llc_way_store.sv
      - rtl/llc_rsp_mux.sv
      - rtl/llc_mem_top.sv
  - target: test
    files:
      - tests/llc_mem_props.sv
      - tests/llc_mem_tb.sv
